//--- verilog.f
+incdir+src
src/isa_pkg.sv
src/pipe_pkg.sv
src/pipe_reg.sv
src/if_stage.sv
src/id_stage.sv
src/ex_stage.sv
src/mem_stage.sv
src/wb_stage.sv
src/core_top.sv
verification/core_checker.sv
verification/core_tb.sv

//--- Bender.yml
package:
  name: rv64i_core

sources:
  - include_dirs:
      - src
    files:
      - src/isa_pkg.sv
      - src/pipe_pkg.sv
      - src/pipe_reg.sv
      - src/if_stage.sv
      - src/id_stage.sv
      - src/ex_stage.sv
      - src/mem_stage.sv
      - src/wb_stage.sv
      - src/core_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/core_checker.sv
      - verification/core_tb.sv

//--- verification/core_tb.sv
// Core testbench with program table
`include "core_settings.svh"

module core_tb;

    localparam int          NUM_TESTS    = 5;
    localparam int          PROG_WORDS   = 8;
    localparam int          HALT_TIMEOUT = 500;
    localparam logic [31:0] EBREAK       = 32'h0010_0073;

    logic               clk;
    logic               arst_n;
    logic [`XLEN-1:0]   imem_addr;
    logic [31:0]        imem_data;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    logic [`XLEN-1:0]   wb_adr;
    logic [`XLEN/8-1:0] wb_sel;
    logic [`XLEN-1:0]   wb_wdata;
    logic [`XLEN-1:0]   wb_rdata;
    logic               wb_ack;
    logic               ret_valid;
    logic [`XLEN-1:0]   ret_pc;
    logic [4:0]         ret_rd;
    logic [`XLEN-1:0]   ret_data;
    logic               halted;
    int                 pass_cnt;
    int                 fail_cnt;

    logic [31:0]        rom [32];
    logic [`XLEN-1:0]   dmem [32];
    logic [31:0]        prog [NUM_TESTS][PROG_WORDS];
    logic [4:0]         tgt_rd [NUM_TESTS];
    logic [`XLEN-1:0]   tgt_val [NUM_TESTS];
    logic [`XLEN-1:0]   tgt_pc [NUM_TESTS];  // pc of the last write to tgt_rd
    string              tgt_name [NUM_TESTS];
    integer             seed = 91;
    int                 wait_left;
    logic               pending;
    logic               timed_out;

    core_top dut (
        .clk_i          (clk),
        .arst_n_i       (arst_n),
        .imem_addr_o    (imem_addr),
        .imem_data_i    (imem_data),
        .wb_cyc_o       (wb_cyc),
        .wb_stb_o       (wb_stb),
        .wb_we_o        (wb_we),
        .wb_adr_o       (wb_adr),
        .wb_sel_o       (wb_sel),
        .wb_dat_o       (wb_wdata),
        .wb_dat_i       (wb_rdata),
        .wb_ack_i       (wb_ack),
        .retire_valid_o (ret_valid),
        .retire_pc_o    (ret_pc),
        .retire_rd_o    (ret_rd),
        .retire_data_o  (ret_data),
        .halted_o       (halted)
    );

    core_checker u_checker (
        .clk_i          (clk),
        .arst_n_i       (arst_n),
        .retire_valid_i (ret_valid),
        .retire_pc_i    (ret_pc),
        .retire_rd_i    (ret_rd),
        .retire_data_i  (ret_data),
        .halted_i       (halted),
        .wb_stb_i       (wb_stb),
        .wb_sel_i       (wb_sel),
        .pass_cnt_o     (pass_cnt),
        .fail_cnt_o     (fail_cnt)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // out-of-range fetches see ebreak
    assign imem_data = (imem_addr < 64'd128) ? rom[imem_addr[6:2]] : EBREAK;

    // data slave, 0 to 3 wait cycles per request
    always @(posedge clk) begin
        if (!arst_n) begin
            wb_ack  <= 1'b0;
            pending = 1'b0;
        end else if (wb_ack) begin
            wb_ack  <= 1'b0;  // master drops cyc next cycle
            pending = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!pending) begin
                pending   = 1'b1;
                wait_left = {$random(seed)} % 4;
            end
            if (wait_left == 0) begin
                wb_ack <= 1'b1;
                if (wb_we) begin
                    dmem[wb_adr[7:3]] = wb_wdata;
                end else begin
                    wb_rdata <= dmem[wb_adr[7:3]];
                end
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    function automatic logic [31:0] r_type(logic [6:0] f7, logic [2:0] f3,
                                           logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] addi(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lui(logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] ld(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b011, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sd(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                           logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal(logic [4:0] rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic fill_tests();
        for (int t = 0; t < NUM_TESTS; t++) begin
            for (int w = 0; w < PROG_WORDS; w++) begin
                prog[t][w] = EBREAK;
            end
        end
        // all eight alu ops chained through forwarding
        tgt_name[0] = "alu_chain";
        tgt_rd[0]   = 5'd8;
        tgt_val[0]  = 64'hFFFF_FFFF_FFFF_E001;
        tgt_pc[0]   = 64'h1C;
        prog[0][0]  = addi(5'd1, 5'd0, 12'd100);
        prog[0][1]  = lui(5'd2, 20'hFFFFF);
        prog[0][2]  = r_type(7'h00, 3'b000, 5'd3, 5'd1, 5'd2);  // add
        prog[0][3]  = r_type(7'h20, 3'b000, 5'd4, 5'd1, 5'd3);  // sub
        prog[0][4]  = r_type(7'h00, 3'b100, 5'd5, 5'd4, 5'd3);  // xor
        prog[0][5]  = r_type(7'h00, 3'b010, 5'd6, 5'd5, 5'd1);  // slt
        prog[0][6]  = r_type(7'h00, 3'b111, 5'd7, 5'd5, 5'd2);  // and
        prog[0][7]  = r_type(7'h00, 3'b110, 5'd8, 5'd7, 5'd6);  // or
        tgt_name[1] = "store_load";
        tgt_rd[1]   = 5'd3;
        tgt_val[1]  = 64'hFFFF_FFFF_EDCB_A988;
        tgt_pc[1]   = 64'h18;
        prog[1][0]  = lui(5'd1, 20'h12345);
        prog[1][1]  = addi(5'd1, 5'd1, 12'h678);
        prog[1][2]  = r_type(7'h20, 3'b000, 5'd1, 5'd0, 5'd1);  // negate
        prog[1][3]  = addi(5'd2, 5'd0, 12'd64);
        prog[1][4]  = sd(5'd1, 5'd2, 12'd8);
        prog[1][5]  = sd(5'd2, 5'd2, 12'd0);  // neighbour word
        prog[1][6]  = ld(5'd3, 5'd2, 12'd8);
        tgt_name[2] = "load_use";
        tgt_rd[2]   = 5'd5;
        tgt_val[2]  = 64'hFFFF_FFFF_FFFF_FDBB;
        tgt_pc[2]   = 64'h14;
        prog[2][0]  = addi(5'd1, 5'd0, 12'hEDD);
        prog[2][1]  = addi(5'd2, 5'd0, 12'd32);
        prog[2][2]  = sd(5'd1, 5'd2, 12'd0);
        prog[2][3]  = ld(5'd3, 5'd2, 12'd0);
        prog[2][4]  = r_type(7'h00, 3'b000, 5'd4, 5'd3, 5'd3);  // uses load at once
        prog[2][5]  = addi(5'd5, 5'd4, 12'd1);
        // every skipped word would change x3
        tgt_name[3] = "branch_jal";
        tgt_rd[3]   = 5'd3;
        tgt_val[3]  = 64'h14;
        tgt_pc[3]   = 64'h10;
        prog[3][0]  = addi(5'd1, 5'd0, 12'd5);
        prog[3][1]  = addi(5'd2, 5'd0, 12'd5);
        prog[3][2]  = branch(3'b000, 5'd1, 5'd2, 13'd8);  // beq taken
        prog[3][3]  = addi(5'd1, 5'd0, 12'd20);
        prog[3][4]  = jal(5'd3, 21'd8);  // link 0x14
        prog[3][5]  = addi(5'd3, 5'd0, 12'd2);
        prog[3][6]  = branch(3'b001, 5'd3, 5'd1, 13'd8);  // bne taken
        prog[3][7]  = addi(5'd3, 5'd0, 12'd3);
        tgt_name[4] = "x0_ebreak";
        tgt_rd[4]   = 5'd1;
        tgt_val[4]  = 64'h7;
        tgt_pc[4]   = 64'h0C;
        prog[4][0]  = addi(5'd0, 5'd0, 12'd55);
        prog[4][1]  = lui(5'd0, 20'h12345);
        prog[4][2]  = r_type(7'h00, 3'b000, 5'd1, 5'd0, 5'd0);
        prog[4][3]  = addi(5'd1, 5'd1, 12'd7);
        prog[4][4]  = EBREAK;
        prog[4][5]  = addi(5'd1, 5'd0, 12'd99);  // never retires
        prog[4][6]  = addi(5'd1, 5'd1, 12'd1);
    endtask

    task automatic reset_core(input int t);
        @(posedge clk);
        arst_n <= 1'b0;
        for (int i = 0; i < 32; i++) begin
            rom[i]  = (i < PROG_WORDS) ? prog[t][i] : EBREAK;
            dmem[i] = '0;
        end
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
    endtask

    task automatic wait_for_halt(output logic expired);
        int cycles;
        cycles = 0;
        while (!halted && cycles < HALT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        expired = !halted;
    endtask

    initial begin
        arst_n   = 1'b0;
        wb_ack   = 1'b0;
        wb_rdata = '0;
        fill_tests();
        for (int t = 0; t < NUM_TESTS; t++) begin
            u_checker.start_test(tgt_name[t]);
            reset_core(t);
            wait_for_halt(timed_out);
            repeat (3) @(negedge clk);  // room for a stray retire
            u_checker.finish_test(tgt_rd[t], tgt_val[t], tgt_pc[t], timed_out);
        end
        $display("tests %0d, passed %0d, failed %0d", NUM_TESTS, pass_cnt, fail_cnt);
        if (fail_cnt == 0 && pass_cnt == NUM_TESTS) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- verification/core_checker.sv
// Retire and halt checker
`include "core_settings.svh"

module core_checker (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               retire_valid_i,
    input  logic [`XLEN-1:0]   retire_pc_i,
    input  logic [4:0]         retire_rd_i,
    input  logic [`XLEN-1:0]   retire_data_i,
    input  logic               halted_i,
    input  logic               wb_stb_i,
    input  logic [`XLEN/8-1:0] wb_sel_i,
    output int                 pass_cnt_o,
    output int                 fail_cnt_o
);

    logic [`XLEN-1:0] last_val [`REG_NUM];  // last retired write per register
    logic [`XLEN-1:0] last_pc [`REG_NUM];   // pc of that write
    string            test_name;
    int               bad_events;

    initial begin
        pass_cnt_o = 0;
        fail_cnt_o = 0;
        bad_events = 0;
        test_name  = "";
    end

    always @(posedge clk_i) begin
        if (arst_n_i && wb_stb_i && wb_sel_i !== {(`XLEN/8){1'b1}}) begin
            $display("[FAIL] %s: wb_sel = 0x%h, expected 0x%h",
                     test_name, wb_sel_i, {(`XLEN/8){1'b1}});
            bad_events = bad_events + 1;
        end
        if (arst_n_i && retire_valid_i) begin
            if (halted_i) begin
                $display("%s: instruction at pc 0x%h retired after halt", test_name, retire_pc_i);
                bad_events = bad_events + 1;
            end
            if (retire_rd_i == 5'd0) begin
                $display("%s: write to x0 reported at pc 0x%h", test_name, retire_pc_i);
                bad_events = bad_events + 1;
            end
            last_val[retire_rd_i] = retire_data_i;
            last_pc[retire_rd_i]  = retire_pc_i;
        end
    end

    task automatic start_test(input string name);
        test_name  = name;
        bad_events = 0;
        for (int r = 0; r < `REG_NUM; r++) begin
            last_val[r] = '0;
            last_pc[r]  = '0;
        end
    endtask

    task automatic finish_test(input logic [4:0] rd, input logic [`XLEN-1:0] expected,
                               input logic [`XLEN-1:0] expected_pc, input logic timed_out);
        if (timed_out) begin
            $display("%s: timed out waiting for the core to halt", test_name);
            fail_cnt_o = fail_cnt_o + 1;
        end else if (last_val[rd] !== expected) begin
            $display("[FAIL] %s: x%0d = 0x%h, expected 0x%h",
                     test_name, rd, last_val[rd], expected);
            fail_cnt_o = fail_cnt_o + 1;
        end else if (last_pc[rd] !== expected_pc) begin
            $display("[FAIL] %s: retire_pc of x%0d = 0x%h, expected 0x%h",
                     test_name, rd, last_pc[rd], expected_pc);
            fail_cnt_o = fail_cnt_o + 1;
        end else if (bad_events != 0) begin
            $display("%s: failed with %0d bad retire or bus events", test_name, bad_events);
            fail_cnt_o = fail_cnt_o + 1;
        end else begin
            $display("[PASS] %s: x%0d = 0x%h", test_name, rd, last_val[rd]);
            pass_cnt_o = pass_cnt_o + 1;
        end
    endtask

endmodule

//--- src/core_top.sv
// Five-stage RV64I core
`include "core_settings.svh"

module core_top
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic               clk_i,
    input  logic               arst_n_i,
    output xword_t             imem_addr_o,
    input  logic [31:0]        imem_data_i,
    output logic               wb_cyc_o,
    output logic               wb_stb_o,
    output logic               wb_we_o,
    output xword_t             wb_adr_o,
    output logic [`XLEN/8-1:0] wb_sel_o,
    output xword_t             wb_dat_o,
    input  xword_t             wb_dat_i,
    input  logic               wb_ack_i,
    output logic               retire_valid_o,
    output xword_t             retire_pc_o,
    output reg_addr_t          retire_rd_o,
    output xword_t             retire_data_o,
    output logic               halted_o
);

    if_id_t    if_fetch;
    if_id_t    id_fetch;
    id_ex_t    id_dec;
    id_ex_t    ex_op;
    ex_mem_t   ex_res;
    ex_mem_t   mem_op;
    mem_wb_t   mem_res;
    mem_wb_t   wb_op;
    bypass_t   ex_byp;
    bypass_t   mem_byp;
    bypass_t   wb_byp;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    xword_t    rs1_data;
    xword_t    rs2_data;
    xword_t    redirect_pc;
    logic      redirect;
    logic      load_stall;
    logic      bus_stall;
    logic      freeze;

    assign freeze = bus_stall | halted_o;  // bus wait or ebreak

    if_stage u_if_stage (
        .*,
        .stall_i       (freeze | load_stall),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .fetch_o       (if_fetch)
    );

    pipe_reg #(.payload_t(if_id_t)) u_if_id (
        .*,
        .stall_i (freeze | load_stall),
        .flush_i (redirect & ~freeze),  // drop the wrong-path fetch
        .d_i     (if_fetch),
        .q_o     (id_fetch)
    );

    id_stage u_id_stage (
        .fetch_i       (id_fetch),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .ex_byp_i      (ex_byp),
        .mem_byp_i     (mem_byp),
        .wb_byp_i      (wb_byp),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .load_stall_o  (load_stall),
        .dec_o         (id_dec)
    );

    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .*,
        .stall_i (freeze),
        .flush_i (load_stall & ~freeze),  // load-use bubble
        .d_i     (id_dec),
        .q_o     (ex_op)
    );

    ex_stage u_ex_stage (
        .op_i  (ex_op),
        .res_o (ex_res),
        .byp_o (ex_byp)
    );

    pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .*,
        .stall_i (freeze),
        .flush_i (1'b0),
        .d_i     (ex_res),
        .q_o     (mem_op)
    );

    mem_stage u_mem_stage (
        .*,
        .op_i        (mem_op),
        .res_o       (mem_res),
        .byp_o       (mem_byp),
        .bus_stall_o (bus_stall)
    );

    // bubbles enter writeback while the bus is busy, so nothing retires twice
    pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .*,
        .stall_i (halted_o),
        .flush_i (bus_stall & ~halted_o),
        .d_i     (mem_res),
        .q_o     (wb_op)
    );

    wb_stage u_wb_stage (
        .*,
        .op_i       (wb_op),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .byp_o      (wb_byp)
    );

endmodule

//--- src/wb_stage.sv
// Writeback, register file and halt
`include "core_settings.svh"

module wb_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  mem_wb_t   op_i,
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    output xword_t    rs1_data_o,
    output xword_t    rs2_data_o,
    output bypass_t   byp_o,
    output logic      retire_valid_o,
    output xword_t    retire_pc_o,
    output reg_addr_t retire_rd_o,
    output xword_t    retire_data_o,
    output logic      halted_o
);

    xword_t regs [`REG_NUM];
    logic   wen;
    logic   halted_q;

    assign wen = op_i.ctrl.reg_wen && op_i.ctrl.rd != '0;

    always_ff @(posedge clk_i) begin
        if (wen) begin
            regs[op_i.ctrl.rd] <= op_i.result;
        end
    end

    // write-through so decode sees this cycle's result
    assign rs1_data_o = (rs1_addr_i == '0)                      ? '0          :
                        (wen && op_i.ctrl.rd == rs1_addr_i)     ? op_i.result : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0)                      ? '0          :
                        (wen && op_i.ctrl.rd == rs2_addr_i)     ? op_i.result : regs[rs2_addr_i];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            halted_q <= 1'b0;
        end else if (op_i.ctrl.ebreak) begin
            halted_q <= 1'b1;  // sticky until reset
        end
    end

    assign halted_o = halted_q | op_i.ctrl.ebreak;

    assign retire_valid_o = wen;
    assign retire_pc_o    = op_i.pc;
    assign retire_rd_o    = op_i.ctrl.rd;
    assign retire_data_o  = op_i.result;

    assign byp_o.valid   = 1'b1;
    assign byp_o.reg_wen = wen;
    assign byp_o.is_load = op_i.ctrl.mem_read;
    assign byp_o.rd      = op_i.ctrl.rd;
    assign byp_o.data    = op_i.result;

    // frozen pipeline behind ebreak must not retire anything
    a_quiet_after_halt: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        halted_q |-> !retire_valid_o
    );

endmodule

//--- src/mem_stage.sv
// Memory stage with Wishbone data master
`include "core_settings.svh"

module mem_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  ex_mem_t            op_i,
    output mem_wb_t            res_o,
    output bypass_t            byp_o,
    output logic               bus_stall_o,
    output logic               wb_cyc_o,
    output logic               wb_stb_o,
    output logic               wb_we_o,
    output xword_t             wb_adr_o,
    output logic [`XLEN/8-1:0] wb_sel_o,
    output xword_t             wb_dat_o,
    input  xword_t             wb_dat_i,
    input  logic               wb_ack_i
);

    logic   mem_op;
    logic   done_q;
    xword_t rdata_q;
    xword_t result;

    assign mem_op = op_i.ctrl.mem_read | op_i.ctrl.mem_write;

    // request held until ack, then one idle cycle while the pipe moves
    assign wb_cyc_o    = mem_op && !done_q;
    assign wb_stb_o    = wb_cyc_o;
    assign wb_we_o     = op_i.ctrl.mem_write;
    assign wb_adr_o    = op_i.alu_res;
    assign wb_sel_o    = '1;  // double words only
    assign wb_dat_o    = op_i.st_data;
    assign bus_stall_o = wb_cyc_o;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            done_q <= 1'b0;
        end else begin
            done_q <= wb_cyc_o && wb_ack_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wb_cyc_o && wb_ack_i && !wb_we_o) begin
            rdata_q <= wb_dat_i;
        end
    end

    assign result = op_i.ctrl.mem_read ? rdata_q : op_i.alu_res;

    assign res_o.pc     = op_i.pc;
    assign res_o.ctrl   = op_i.ctrl;
    assign res_o.result = result;

    assign byp_o.valid   = !op_i.ctrl.mem_read || done_q;
    assign byp_o.reg_wen = op_i.ctrl.reg_wen;
    assign byp_o.is_load = op_i.ctrl.mem_read;
    assign byp_o.rd      = op_i.ctrl.rd;
    assign byp_o.data    = result;

    // address comes from the ex/mem register, frozen by the bus stall
    a_adr_stable: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (wb_stb_o && !wb_ack_i) |=> (wb_stb_o && $stable(wb_adr_o))
    );

endmodule

//--- src/ex_stage.sv
// Execute stage ALU
`include "core_settings.svh"

module ex_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  id_ex_t  op_i,
    output ex_mem_t res_o,
    output bypass_t byp_o
);

    xword_t alu_res;
    logic   lt;

    assign lt = $signed(op_i.op_a) < $signed(op_i.op_b);

    always_comb begin
        case (op_i.ctrl.alu_op)
            ALU_SUB:    alu_res = op_i.op_a - op_i.op_b;
            ALU_AND:    alu_res = op_i.op_a & op_i.op_b;
            ALU_OR:     alu_res = op_i.op_a | op_i.op_b;
            ALU_XOR:    alu_res = op_i.op_a ^ op_i.op_b;
            ALU_SLT:    alu_res = {{(`XLEN-1){1'b0}}, lt};
            ALU_PASS_B: alu_res = op_i.op_b;
            default:    alu_res = op_i.op_a + op_i.op_b;  // add and address
        endcase
    end

    assign res_o.pc      = op_i.pc;
    assign res_o.ctrl    = op_i.ctrl;
    assign res_o.alu_res = alu_res;
    assign res_o.st_data = op_i.st_data;

    assign byp_o.valid   = !op_i.ctrl.mem_read;  // load data not here yet
    assign byp_o.reg_wen = op_i.ctrl.reg_wen;
    assign byp_o.is_load = op_i.ctrl.mem_read;
    assign byp_o.rd      = op_i.ctrl.rd;
    assign byp_o.data    = alu_res;

endmodule

//--- src/id_stage.sv
// Decode, forwarding and branch resolution
`include "core_settings.svh"

module id_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  if_id_t    fetch_i,
    output reg_addr_t rs1_addr_o,
    output reg_addr_t rs2_addr_o,
    input  xword_t    rs1_data_i,
    input  xword_t    rs2_data_i,
    input  bypass_t   ex_byp_i,
    input  bypass_t   mem_byp_i,
    input  bypass_t   wb_byp_i,
    output logic      redirect_o,
    output xword_t    redirect_pc_o,
    output logic      load_stall_o,
    output id_ex_t    dec_o
);

    logic [31:0] instr;
    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    reg_addr_t   rd;
    xword_t      imm_i;
    xword_t      imm_s;
    xword_t      imm_b;
    xword_t      imm_u;
    xword_t      imm_j;
    xword_t      rs1_val;
    xword_t      rs2_val;
    xword_t      op_b;
    logic        uses_rs1;
    logic        uses_rs2;
    logic        taken;
    ctrl_t       ctrl;

    function automatic logic hit(bypass_t byp, reg_addr_t addr);
        return byp.valid && byp.reg_wen && byp.rd == addr;
    endfunction

    assign instr      = fetch_i.instr;
    assign opcode     = opcode_e'(instr[6:0]);
    assign rd         = instr[11:7];
    assign funct3     = instr[14:12];
    assign funct7     = instr[31:25];
    assign rs1_addr_o = instr[19:15];
    assign rs2_addr_o = instr[24:20];

    assign imm_i = {{(`XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{(`XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {{(`XLEN-32){instr[31]}}, instr[31:12], 12'b0};
    assign imm_j = {{(`XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    // youngest producer first
    assign rs1_val = (rs1_addr_o == '0)         ? '0             :
                     hit(ex_byp_i, rs1_addr_o)  ? ex_byp_i.data  :
                     hit(mem_byp_i, rs1_addr_o) ? mem_byp_i.data :
                     hit(wb_byp_i, rs1_addr_o)  ? wb_byp_i.data  : rs1_data_i;
    assign rs2_val = (rs2_addr_o == '0)         ? '0             :
                     hit(ex_byp_i, rs2_addr_o)  ? ex_byp_i.data  :
                     hit(mem_byp_i, rs2_addr_o) ? mem_byp_i.data :
                     hit(wb_byp_i, rs2_addr_o)  ? wb_byp_i.data  : rs2_data_i;

    always_comb begin
        ctrl          = '0;
        ctrl.rd       = rd;
        op_b          = rs2_val;
        taken         = 1'b0;
        redirect_pc_o = fetch_i.pc + imm_b;
        case (opcode)
            OPC_OP_IMM: ctrl.reg_wen = (funct3 == 3'b000);  // addi only
            OPC_OP: begin
                ctrl.reg_wen = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: ctrl.alu_op = ALU_ADD;
                    10'b0100000_000: ctrl.alu_op = ALU_SUB;
                    10'b0000000_111: ctrl.alu_op = ALU_AND;
                    10'b0000000_110: ctrl.alu_op = ALU_OR;
                    10'b0000000_100: ctrl.alu_op = ALU_XOR;
                    10'b0000000_010: ctrl.alu_op = ALU_SLT;
                    default:         ctrl.reg_wen = 1'b0;
                endcase
            end
            OPC_LUI: begin
                ctrl.reg_wen = 1'b1;
                ctrl.alu_op  = ALU_PASS_B;
            end
            OPC_LOAD: begin
                ctrl.reg_wen  = (funct3 == 3'b011);  // ld only
                ctrl.mem_read = (funct3 == 3'b011);
            end
            OPC_STORE: ctrl.mem_write = (funct3 == 3'b011);  // sd only
            OPC_BRANCH: begin
                if (funct3 == 3'b000) begin
                    taken = (rs1_val == rs2_val);
                end else if (funct3 == 3'b001) begin
                    taken = (rs1_val != rs2_val);
                end
            end
            OPC_JAL: begin
                ctrl.reg_wen  = 1'b1;
                ctrl.alu_op   = ALU_PASS_B;
                taken         = 1'b1;
                redirect_pc_o = fetch_i.pc + imm_j;
            end
            OPC_SYSTEM: ctrl.ebreak = (instr == EBREAK_WORD);
            default: ;  // unknown opcode leaves a bubble
        endcase
        case (opcode)
            OPC_OP_IMM, OPC_LOAD: op_b = imm_i;
            OPC_STORE:            op_b = imm_s;
            OPC_LUI:              op_b = imm_u;
            OPC_JAL:              op_b = fetch_i.pc + 4;  // link value
            default: ;
        endcase
        if (rd == '0) begin
            ctrl.reg_wen = 1'b0;  // x0 stays zero
        end
        if (!fetch_i.valid) begin
            ctrl  = '0;
            taken = 1'b0;
        end
    end

    assign uses_rs1 = !(opcode inside {OPC_LUI, OPC_JAL});
    assign uses_rs2 = opcode inside {OPC_OP, OPC_STORE, OPC_BRANCH};

    // ld in execute feeding this instruction
    assign load_stall_o = fetch_i.valid && ex_byp_i.is_load && ex_byp_i.rd != '0 &&
                          ((uses_rs1 && ex_byp_i.rd == rs1_addr_o) ||
                           (uses_rs2 && ex_byp_i.rd == rs2_addr_o));
    assign redirect_o   = taken && !load_stall_o;

    assign dec_o.pc      = fetch_i.pc;
    assign dec_o.ctrl    = ctrl;
    assign dec_o.op_a    = rs1_val;
    assign dec_o.op_b    = op_b;
    assign dec_o.st_data = rs2_val;

endmodule

//--- src/if_stage.sv
// Program counter and instruction fetch
`include "core_settings.svh"

module if_stage
    import pipe_pkg::*;
(
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic        stall_i,
    input  logic        redirect_i,
    input  xword_t      redirect_pc_i,
    output xword_t      imem_addr_o,
    input  logic [31:0] imem_data_i,
    output if_id_t      fetch_o
);

    xword_t pc_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= `RESET_PC;
        end else if (!stall_i) begin
            pc_q <= redirect_i ? redirect_pc_i : pc_q + 4;  // taken branch or jal
        end
    end

    assign imem_addr_o   = pc_q;
    assign fetch_o.pc    = pc_q;
    assign fetch_o.instr = imem_data_i;  // combinational rom read
    assign fetch_o.valid = 1'b1;

    // branch and jal targets from decode keep word alignment
    a_pc_aligned: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        pc_q[1:0] == 2'b00
    );

endmodule

//--- src/pipe_reg.sv
// Pipeline register with stall and flush
module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     stall_i,
    input  logic     flush_i,
    input  payload_t d_i,
    output payload_t q_o
);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            q_o <= '0;
        end else if (flush_i) begin
            q_o <= '0;  // all-zero payload is a bubble
        end else if (!stall_i) begin
            q_o <= d_i;
        end
    end

    // the top level gates every flush with the bus stall and halt freeze
    a_no_flush_on_stall: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        !(flush_i && stall_i)
    );

endmodule

//--- src/pipe_pkg.sv
// Pipeline boundary payloads
`include "core_settings.svh"

package pipe_pkg;
    import isa_pkg::*;

    typedef logic [`XLEN-1:0] xword_t;

    typedef struct packed {
        xword_t      pc;
        logic [31:0] instr;
        logic        valid;
    } if_id_t;

    typedef struct packed {
        xword_t pc;
        ctrl_t  ctrl;
        xword_t op_a;
        xword_t op_b;
        xword_t st_data;
    } id_ex_t;

    typedef struct packed {
        xword_t pc;
        ctrl_t  ctrl;
        xword_t alu_res;   // effective address for ld/sd
        xword_t st_data;
    } ex_mem_t;

    typedef struct packed {
        xword_t pc;
        ctrl_t  ctrl;
        xword_t result;
    } mem_wb_t;

    // forwarding source seen by decode
    typedef struct packed {
        logic      valid;    // data field is ready
        logic      reg_wen;
        logic      is_load;
        reg_addr_t rd;
        xword_t    data;
    } bypass_t;

endpackage

//--- src/isa_pkg.sv
// RV64I encodings and decoded control
`include "core_settings.svh"

package isa_pkg;

    localparam int REG_AW = $clog2(`REG_NUM);

    typedef logic [REG_AW-1:0] reg_addr_t;

    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,  // also the bubble value
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SLT    = 3'd5,
        ALU_PASS_B = 3'd6   // lui and jal link value
    } alu_op_e;

    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

    typedef struct packed {
        reg_addr_t rd;
        logic      reg_wen;
        logic      mem_read;   // ld
        logic      mem_write;  // sd
        alu_op_e   alu_op;
        logic      ebreak;
    } ctrl_t;

endpackage

//--- src/core_settings.svh
// Core configuration macros
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// data and address width
`define XLEN 64

// integer register count
`define REG_NUM 32

// first fetch address
`define RESET_PC 64'h0

`endif
